/* tiny10.f */
cpu_isa_pkg.sv
cpu_bus_pkg.sv
fetch_unit.sv
instr_decoder.sv
register_file.sv
alu.sv
writeback_stage.sv
cpu_top.sv
tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tiny10 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cpu_top -f tiny10.f -o tb_cpu_top
./obj_dir/tb_cpu_top | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* tb_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Directed testbench for the tiny10 core, Wishbone instruction memory with wait states
module tb_cpu_top;

    localparam int data_w     = 10;
    localparam int clk_period = 100;
    localparam int max_instr  = 48;  // Fetches over all programs, rounded up
    localparam int halt_limit = 200; // Cycles for one program to reach HALT
    localparam int wd_cycles  = max_instr * (4 + 3 + 3) + 6 * (10 + 4) + 20 + 200;

    logic                 clk;
    logic                 arst_n;
    logic                 branch;
    logic [9:0]           branch_addr;
    cpu_bus_pkg::wb_rsp_t wb_rsp;
    cpu_bus_pkg::wb_req_t wb_req;
    logic [data_w-1:0]    alu_result;
    logic                 result_valid;
    logic                 alu_halt;
    logic [9:0]           pc_out;

    logic [15:0]       mem [1024];      // Instruction memory
    logic [data_w-1:0] model_regs [8];  // Reference register file
    logic [data_w-1:0] last_res;        // Value alu_result holds
    logic [data_w-1:0] exp_q [$];       // Results still to come
    logic [9:0]        prog_pc;         // Next word to load
    logic [31:0]       lfsr;
    logic [1:0]        wait_left;
    logic              in_xfer;
    string             test_name;
    int                cyc_cnt = 0;
    int                ack_edge, res_count, exp_count;
    int                errors, test_errors, tests, failed;

    cpu_top #(.data_w(data_w)) cpu_top_inst (
        .clk(clk), .arst_n(arst_n), .branch(branch), .branch_addr(branch_addr),
        .wb_rsp(wb_rsp), .wb_req(wb_req), .alu_result(alu_result),
        .result_valid(result_valid), .alu_halt(alu_halt), .pc_out(pc_out)
    );

    always #(clk_period / 2) clk = ~clk;
    always @(posedge clk) cyc_cnt <= cyc_cnt + 1; // Edge counter for latency checks

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr); // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // --------------------
    // Memory slave
    // --------------------
    always @(posedge clk or negedge arst_n) begin
        logic [31:0] v;
        if (arst_n) begin
            #1; // Drive after the edge
        end
        if (!arst_n) begin
            wb_rsp  = '0;
            in_xfer = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0; // Single-cycle ack
            in_xfer    = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!in_xfer) begin
                in_xfer = 1'b1;
                draw_bits(2, v);
                wait_left = v[1:0]; // 0 to 3 wait states
            end else if (wait_left != 2'd0) begin
                wait_left = wait_left - 2'd1;
            end
            if (wait_left == 2'd0) begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = mem[wb_req.adr];
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    endtask

    // Result and latency monitor
    always @(negedge clk) begin
        logic [data_w-1:0] e;
        if (arst_n && wb_req.cyc && wb_rsp.ack) ack_edge = cyc_cnt + 1; // Ack taken next edge
        if (arst_n && result_valid) begin
            res_count++;
            if (exp_q.size() == 0) begin
                $display("%s: result_valid with no instruction owing a result", test_name);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (alu_result !== e) report_mismatch("alu_result", 16'(alu_result), 16'(e));
            end
            if (cyc_cnt - ack_edge != 3) begin
                $display("%s: result_valid came %0d cycles after its ack, not 3",
                         test_name, cyc_cnt - ack_edge);
                errors++;
            end
        end
    end

    // --------------------
    // Program builder and model
    // --------------------
    task automatic load_word(input logic [15:0] w);
        mem[prog_pc] = w;
        prog_pc      = prog_pc + 10'd1;
    endtask

    task automatic expect_result(input logic [data_w-1:0] r);
        exp_q.push_back(r);
        exp_count++;
        last_res = r;
    endtask

    task automatic emit_r(input logic [3:0] op, input logic [2:0] rd, rs, rt);
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] r;
        a = model_regs[rs];
        b = model_regs[rt];
        case (op)
            cpu_isa_pkg::op_sub: r = a - b;
            cpu_isa_pkg::op_and: r = a & b;
            cpu_isa_pkg::op_or:  r = a | b;
            cpu_isa_pkg::op_xor: r = a ^ b;
            default:             r = a + b; // Wraps at 10 bits
        endcase
        load_word({op, rd, rs, rt, 3'b000});
        model_regs[rd] = r;
        expect_result(r);
    endtask

    task automatic emit_i(input logic [2:0] rd, rs, input logic [5:0] imm);
        logic [data_w-1:0] r;
        r = model_regs[rs] + {{(data_w - 6){imm[5]}}, imm}; // Signed immediate
        load_word({cpu_isa_pkg::op_addi, rd, rs, imm});
        model_regs[rd] = r;
        expect_result(r);
    endtask

    task automatic emit_halt();
        load_word({cpu_isa_pkg::op_halt, 12'h000});
        expect_result(last_res); // Strobes, value unchanged
    endtask

    // --------------------
    // Test flow
    // --------------------
    task automatic start_test(input string name);
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        for (int a = 0; a < 1024; a++) begin
            mem[a[9:0]] = {4'he, a[9:0], 2'b01}; // No-op opcode, word follows address
        end
        for (int r = 0; r < 8; r++) begin
            model_regs[r[2:0]] = '0;
        end
        exp_q.delete();
        prog_pc     = '0;
        last_res    = '0;
        res_count   = 0;
        exp_count   = 0;
        test_errors = errors;
        test_name   = name;
        tests++;
    endtask

    task automatic release_reset();
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        if (wb_req.cyc !== 1'b0) report_mismatch("wb_req.cyc", 16'(wb_req.cyc), 16'h0);
        if (wb_req.stb !== 1'b0) report_mismatch("wb_req.stb", 16'(wb_req.stb), 16'h0);
        if (result_valid !== 1'b0) report_mismatch("result_valid", 16'(result_valid), 16'h0);
        if (alu_halt !== 1'b0) report_mismatch("alu_halt", 16'(alu_halt), 16'h0);
        if (pc_out !== 10'd0) report_mismatch("pc_out", 16'(pc_out), 16'h0);
        if (alu_result !== '0) report_mismatch("alu_result", 16'(alu_result), 16'h0);
        arst_n = 1'b1;
    endtask

    task automatic wait_halt(input logic [9:0] exp_pc);
        int n;
        n = 0;
        while (!alu_halt && n < halt_limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!alu_halt) begin
            $display("%s: alu_halt did not rise within %0d cycles", test_name, halt_limit);
            errors++;
        end
        repeat (2) begin // Let the halt strobe reach the monitor
            @(posedge clk);
            #1;
        end
        if (res_count != exp_count) begin
            report_mismatch("result_valid count", 16'(res_count), 16'(exp_count));
        end
        if (pc_out !== exp_pc) report_mismatch("pc_out", 16'(pc_out), 16'(exp_pc));
    endtask

    task automatic finish_test();
        if (errors == test_errors) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, errors - test_errors);
            failed++;
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic alu_operations();
        logic [31:0] v;
        start_test("alu_operations");
        for (int i = 1; i <= 4; i++) begin
            draw_bits(6, v);
            emit_i(3'(i), 3'(i / 3), v[5:0]); // r3, r4 build on r1
        end
        emit_r(cpu_isa_pkg::op_add, 3'd5, 3'd1, 3'd2);
        emit_r(cpu_isa_pkg::op_sub, 3'd6, 3'd3, 3'd4);
        emit_r(cpu_isa_pkg::op_and, 3'd7, 3'd5, 3'd6);
        emit_r(cpu_isa_pkg::op_or,  3'd1, 3'd6, 3'd3);
        emit_r(cpu_isa_pkg::op_xor, 3'd2, 3'd7, 3'd1);
        emit_r(cpu_isa_pkg::op_add, 3'd3, 3'd2, 3'd2);
        emit_r(cpu_isa_pkg::op_sub, 3'd4, 3'd0, 3'd3); // Below zero, wraps
        emit_halt();
        release_reset();
        wait_halt(prog_pc);
        finish_test();
    endtask

    task automatic negative_immediates();
        start_test("negative_immediates");
        emit_i(3'd1, 3'd0, 6'h3f); // 0 + (-1)
        emit_i(3'd2, 3'd0, 6'h20); // Most negative immediate
        emit_i(3'd3, 3'd1, 6'h3f);
        emit_i(3'd4, 3'd2, 6'h1f);
        emit_halt();
        release_reset();
        wait_halt(prog_pc);
        finish_test();
    endtask

    task automatic register_dependencies();
        start_test("register_dependencies");
        emit_i(3'd1, 3'd0, 6'd7);
        emit_r(cpu_isa_pkg::op_add, 3'd2, 3'd1, 3'd1); // Each reads the previous rd
        emit_r(cpu_isa_pkg::op_sub, 3'd3, 3'd2, 3'd1);
        emit_r(cpu_isa_pkg::op_xor, 3'd1, 3'd3, 3'd2);
        emit_r(cpu_isa_pkg::op_or,  3'd4, 3'd1, 3'd3);
        emit_r(cpu_isa_pkg::op_and, 3'd5, 3'd4, 3'd1);
        emit_halt();
        release_reset();
        wait_halt(prog_pc);
        finish_test();
    endtask

    task automatic wait_states();
        logic [31:0] v;
        start_test("wait_states");
        for (int i = 0; i < 8; i++) begin
            draw_bits(6, v);
            if (i == 4) load_word({4'd9, 12'h5a5}); // No-op, owes no result
            emit_i(3'(i), 3'((i + 7) % 8), v[5:0]);
        end
        emit_r(cpu_isa_pkg::op_xor, 3'd6, 3'd7, 3'd3);
        emit_r(cpu_isa_pkg::op_sub, 3'd2, 3'd6, 3'd5);
        emit_halt();
        release_reset();
        wait_halt(prog_pc);
        finish_test();
    endtask

    task automatic branch_redirect();
        start_test("branch_redirect");
        emit_i(3'd1, 3'd0, 6'd5);
        emit_i(3'd2, 3'd1, 6'd3);
        load_word({cpu_isa_pkg::op_addi, 3'd3, 3'd0, 6'h39}); // Dropped by the redirect
        load_word({cpu_isa_pkg::op_halt, 12'h000});
        prog_pc = 10'h100;
        emit_r(cpu_isa_pkg::op_add, 3'd4, 3'd1, 3'd2);
        emit_r(cpu_isa_pkg::op_xor, 3'd5, 3'd4, 3'd1);
        emit_halt();
        release_reset();
        while (!(wb_req.cyc && wb_req.adr == 10'd2)) begin
            @(posedge clk);
            #1;
        end
        branch      = 1'b1; // Mid-cycle redirect
        branch_addr = 10'h100;
        @(posedge clk);
        #1;
        branch = 1'b0;
        if (pc_out !== 10'h100) report_mismatch("pc_out", 16'(pc_out), 16'h100);
        while (wb_req.cyc) begin // Stale cycle still runs to its ack
            @(posedge clk);
            #1;
        end
        while (!wb_req.cyc) begin
            @(posedge clk);
            #1;
        end
        if (wb_req.adr !== 10'h100) report_mismatch("wb_req.adr", 16'(wb_req.adr), 16'h100);
        wait_halt(10'h103);
        finish_test();
    endtask

    task automatic halt_stop();
        int cyc_seen;
        start_test("halt_stop");
        emit_i(3'd1, 3'd0, 6'd9);
        emit_halt();
        load_word({cpu_isa_pkg::op_addi, 3'd2, 3'd0, 6'd3}); // Never fetched
        release_reset();
        wait_halt(10'd2);
        cyc_seen = 0;
        repeat (20) begin
            @(posedge clk);
            #1;
            if (wb_req.cyc) cyc_seen++;
        end
        if (cyc_seen != 0) begin
            $display("%s: bus cycle started after halt", test_name);
            errors++;
        end
        if (alu_halt !== 1'b1) report_mismatch("alu_halt", 16'(alu_halt), 16'h1);
        finish_test();
    endtask

    // Watchdog
    initial begin
        #(wd_cycles * clk_period);
        $display("watchdog: run did not finish within %0d cycles", wd_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        branch      = 1'b0;
        branch_addr = '0;
        wb_rsp      = '0;
        lfsr        = 32'h42f0_8b1b;
        in_xfer     = 1'b0;
        wait_left   = '0;
        ack_edge    = -100;
        errors      = 0;
        tests       = 0;
        failed      = 0;
        alu_operations();
        negative_immediates();
        register_dependencies();
        wait_states();
        branch_redirect();
        halt_stop();
        $display("tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

// tiny10 core: fetch, decode, register file, ALU, write-back
module cpu_top #(
    parameter int data_w = 10
) (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            branch,       // External redirect
    input  wire [cpu_bus_pkg::adr_w-1:0]   branch_addr,
    input  wire cpu_bus_pkg::wb_rsp_t      wb_rsp,
    output cpu_bus_pkg::wb_req_t           wb_req,
    output logic [data_w-1:0]              alu_result,   // Last written value
    output logic                           result_valid,
    output logic                           alu_halt,
    output logic [cpu_bus_pkg::adr_w-1:0]  pc_out        // Next fetch address
);

    logic                                instr_valid;
    logic [cpu_isa_pkg::instr_w-1:0]     instr;
    logic                                busy;
    logic                                exec_valid;
    cpu_isa_pkg::ctrl_t                  ctrl;
    logic [data_w-1:0]                   imm_ext;
    logic [data_w-1:0]                   rdata1, rdata2;
    logic [data_w-1:0]                   alu_out;
    logic                                halt_flag;   // Combinational, from ALU
    logic                                we;
    logic [cpu_isa_pkg::reg_addr_w-1:0]  waddr;
    logic [data_w-1:0]                   wdata;

    // --------------------
    // Input side
    // --------------------
    fetch_unit fetch_unit_inst (
        .clk(clk), .arst_n(arst_n),
        .branch(branch), .branch_addr(branch_addr),
        .wb_rsp(wb_rsp), .busy(busy), .halt(alu_halt),
        .wb_req(wb_req), .instr_valid(instr_valid), .instr(instr),
        .pc_out(pc_out)
    );

    // --------------------
    // Processing
    // --------------------
    instr_decoder #(.data_w(data_w)) instr_decoder_inst (
        .clk(clk), .arst_n(arst_n),
        .instr_valid(instr_valid), .instr(instr),
        .wb_done(result_valid),          // Write-back strobe ends busy
        .busy(busy), .exec_valid(exec_valid), .ctrl(ctrl), .imm_ext(imm_ext)
    );

    register_file #(.data_w(data_w)) register_file_inst (
        .clk(clk), .arst_n(arst_n),
        .we(we), .waddr(waddr), .wdata(wdata),
        .raddr1(ctrl.rs), .raddr2(ctrl.rt),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    alu #(.data_w(data_w)) alu_inst (
        .a(rdata1), .b(rdata2), .imm(imm_ext), .imm_valid(ctrl.imm_valid),
        .alu_op(ctrl.alu_op),
        .result(alu_out), .halt(halt_flag)
    );

    // Output side
    writeback_stage #(.data_w(data_w)) writeback_stage_inst (
        .clk(clk), .arst_n(arst_n),
        .exec_valid(exec_valid), .ctrl(ctrl),
        .alu_out(alu_out), .alu_halt_in(halt_flag),
        .we(we), .waddr(waddr), .wdata(wdata),
        .result_valid(result_valid), .alu_result(alu_result), .alu_halt(alu_halt)
    );

endmodule

`default_nettype wire

/* writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// Result register, register-file write and sticky halt
module writeback_stage #(
    parameter int data_w = 10
) (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire                                 exec_valid,
    input  wire cpu_isa_pkg::ctrl_t             ctrl,
    input  wire [data_w-1:0]                    alu_out,
    input  wire                                 alu_halt_in,
    output logic                                we,           // One-cycle write
    output logic [cpu_isa_pkg::reg_addr_w-1:0]  waddr,
    output logic [data_w-1:0]                   wdata,
    output logic                                result_valid, // Also wb_done
    output logic [data_w-1:0]                   alu_result,
    output logic                                alu_halt      // Sticky until reset
);

    logic [data_w-1:0] res_q;
    logic              do_write;

    assign do_write   = exec_valid && ctrl.reg_write;
    assign wdata      = res_q;
    assign alu_result = res_q;

    // --------------------
    // Control and result
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we           <= 1'b0;
            result_valid <= 1'b0;
            alu_halt     <= 1'b0;
            res_q        <= '0;
        end else begin
            we           <= do_write;
            result_valid <= do_write || (exec_valid && alu_halt_in); // Halt pulses too
            if (exec_valid && alu_halt_in) alu_halt <= 1'b1;
            if (do_write)                  res_q    <= alu_out; // Halt keeps last value
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) waddr <= ctrl.rd;
    end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

// Combinational ALU with operand select and halt detect
module alu #(
    parameter int data_w = 10
) (
    input  wire [data_w-1:0]           a,         // rs value
    input  wire [data_w-1:0]           b,         // rt value
    input  wire [data_w-1:0]           imm,       // Sign-extended immediate
    input  wire                        imm_valid,
    input  wire cpu_isa_pkg::opcode_e  alu_op,
    output logic [data_w-1:0]          result,
    output logic                       halt
);

    logic [data_w-1:0] opb;

    assign opb = imm_valid ? imm : b; // Second operand

    // --------------------
    // Operation select
    // --------------------
    always_comb begin
        result = '0;
        halt   = 1'b0;
        case (alu_op)
            cpu_isa_pkg::op_add,
            cpu_isa_pkg::op_addi: result = a + opb; // Wraps at data_w
            cpu_isa_pkg::op_sub:  result = a - opb;
            cpu_isa_pkg::op_and:  result = a & opb;
            cpu_isa_pkg::op_or:   result = a | opb;
            cpu_isa_pkg::op_xor:  result = a ^ opb;
            cpu_isa_pkg::op_halt: halt   = 1'b1;
            default:              result = '0;   // No-op codes
        endcase
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

// Eight-entry register file, 2 read ports, 1 write port
module register_file #(
    parameter int data_w = 10
) (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire                                 we,
    input  wire [cpu_isa_pkg::reg_addr_w-1:0]   waddr,
    input  wire [data_w-1:0]                    wdata,
    input  wire [cpu_isa_pkg::reg_addr_w-1:0]   raddr1,
    input  wire [cpu_isa_pkg::reg_addr_w-1:0]   raddr2,
    output logic [data_w-1:0]                   rdata1,
    output logic [data_w-1:0]                   rdata2
);

    logic [data_w-1:0] regs [cpu_isa_pkg::num_regs];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < cpu_isa_pkg::num_regs; i++) begin
                regs[i] <= '0; // All registers start at zero
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads, no bypass needed
    assign rdata1 = regs[raddr1]; // rs
    assign rdata2 = regs[raddr2]; // rt

endmodule

`default_nettype wire

/* instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

// Instruction register and field decode
module instr_decoder #(
    parameter int data_w = 10
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             instr_valid,
    input  wire [cpu_isa_pkg::instr_w-1:0]  instr,
    input  wire                             wb_done,    // Write-back strobe
    output logic                            busy,
    output logic                            exec_valid, // One-cycle pulse
    output cpu_isa_pkg::ctrl_t              ctrl,
    output logic [data_w-1:0]               imm_ext
);

    cpu_isa_pkg::instr_u ir;
    cpu_isa_pkg::ctrl_t  ctrl_d;
    logic                ir_valid;
    logic                busy_q;
    logic                nop_done; // No-op finished, no strobe from write-back

    // --------------------
    // Field decode
    // --------------------
    always_comb begin
        ctrl_d        = '0;
        ctrl_d.alu_op = cpu_isa_pkg::opcode_e'(ir.r.opcode);
        ctrl_d.rd     = ir.r.rd; // rd, rs share both views
        ctrl_d.rs     = ir.r.rs;
        case (ir.r.opcode)
            cpu_isa_pkg::op_add, cpu_isa_pkg::op_sub, cpu_isa_pkg::op_and,
            cpu_isa_pkg::op_or, cpu_isa_pkg::op_xor: begin
                ctrl_d.rt        = ir.r.rt; // R view
                ctrl_d.reg_write = 1'b1;
            end
            cpu_isa_pkg::op_addi: begin
                ctrl_d.imm_valid = 1'b1; // I view
                ctrl_d.imm       = ir.i.imm;
                ctrl_d.reg_write = 1'b1;
            end
            cpu_isa_pkg::op_halt: ctrl_d.reg_write = 1'b0;
            default:              ctrl_d.alu_op = cpu_isa_pkg::op_add; // No-op
        endcase
    end

    assign imm_ext = {{(data_w - cpu_isa_pkg::imm_w){ctrl.imm[cpu_isa_pkg::imm_w-1]}}, ctrl.imm};

    // Released in the cycle write-back finishes so the next fetch can start
    assign busy = busy_q && !(wb_done || nop_done);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir_valid   <= 1'b0;
            exec_valid <= 1'b0;
            busy_q     <= 1'b0;
            nop_done   <= 1'b0;
        end else begin
            ir_valid   <= instr_valid;
            exec_valid <= ir_valid;
            nop_done   <= exec_valid && !ctrl.reg_write &&
                          (ctrl.alu_op != cpu_isa_pkg::op_halt);
            if (instr_valid)              busy_q <= 1'b1;
            else if (wb_done || nop_done) busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) ir   <= instr;  // Raw word into the union
        if (ir_valid)    ctrl <= ctrl_d; // Held through execute
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// Program counter and Wishbone read master
module fetch_unit (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                branch,      // Redirect request
    input  wire [cpu_bus_pkg::adr_w-1:0]       branch_addr,
    input  wire cpu_bus_pkg::wb_rsp_t          wb_rsp,
    input  wire                                busy,        // Decoder back-pressure
    input  wire                                halt,        // Sticky, stops fetch
    output cpu_bus_pkg::wb_req_t               wb_req,
    output logic                               instr_valid, // One-cycle pulse
    output logic [cpu_isa_pkg::instr_w-1:0]    instr,
    output logic [cpu_bus_pkg::adr_w-1:0]      pc_out
);

    typedef enum logic {
        st_idle,
        st_cycle
    } state_e;

    state_e                        state;
    logic [cpu_bus_pkg::adr_w-1:0] pc;      // Next fetch address
    logic [cpu_bus_pkg::adr_w-1:0] adr_q;   // Held for the whole cycle
    logic                          discard; // Branch seen mid-cycle
    logic                          in_cycle;

    assign in_cycle = (state == st_cycle);
    assign wb_req   = '{cyc: in_cycle, stb: in_cycle, adr: adr_q};
    assign pc_out   = pc;

    // --------------------
    // Bus sequencer
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            pc          <= '0;
            adr_q       <= '0;
            discard     <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0; // Default, pulse only
            case (state)
                st_idle: begin
                    if (branch) begin
                        pc <= branch_addr; // Start from the new PC next cycle
                    end else if (!busy && !instr_valid && !halt) begin
                        state   <= st_cycle;
                        adr_q   <= pc;
                        discard <= 1'b0;
                    end
                end
                st_cycle: begin
                    // Cycle runs on, only the word is dropped
                    if (branch) begin
                        pc      <= branch_addr;
                        discard <= 1'b1;
                    end
                    if (wb_rsp.ack) begin
                        state <= st_idle; // Drop cyc and stb at least one cycle
                        if (!branch && !discard) begin
                            instr_valid <= 1'b1;
                            pc          <= adr_q + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Instruction word capture, payload only
    always_ff @(posedge clk) begin
        if (in_cycle && wb_rsp.ack) begin
            instr <= wb_rsp.dat;
        end
    end

endmodule

`default_nettype wire

/* cpu_bus_pkg.sv */
`default_nettype none

// Wishbone classic instruction port, read only
package cpu_bus_pkg;

    localparam int adr_w = 10; // Word address, same as the PC
    localparam int dat_w = 16; // One instruction per word

    // Master to slave
    typedef struct packed {
        logic             cyc; // Bus cycle in progress
        logic             stb; // Transfer request
        logic [adr_w-1:0] adr;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic             ack; // Ends the transfer, dat valid
        logic [dat_w-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* cpu_isa_pkg.sv */
`default_nettype none

// tiny10 instruction set: opcodes, word layouts and decoded control
package cpu_isa_pkg;

    localparam int instr_w    = 16; // Instruction word from the bus
    localparam int reg_addr_w = 3;  // Eight architectural registers
    localparam int num_regs   = 8;
    localparam int imm_w      = 6;  // Signed immediate of the I form

    // Codes not listed here decode as no-ops
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_addi = 4'd5,
        op_halt = 4'd15
    } opcode_e;

    // Register form, rd = rs op rt
    typedef struct packed {
        logic [3:0]            opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [2:0]            unused; // Ignored by the decoder
    } instr_r_t;

    // Immediate form, rd = rs + imm
    typedef struct packed {
        logic [3:0]            opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [imm_w-1:0]      imm;
    } instr_i_t;

    // Same 16 bits, two views; opcode sits in the same place in both
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        opcode_e               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic                  imm_valid; // Immediate replaces rt
        logic [imm_w-1:0]      imm;       // Raw, extended in the decoder
        logic                  reg_write;
    } ctrl_t;

endpackage

`default_nettype wire
